// ==== logic/stlb_cfg_regs.sv ====
// shared TLB configuration block
// translation enables, asid, flush strobe and lookup/hit counters
`timescale 1ns/1ps

module stlb_cfg_regs
  import stlb_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   cfg_we_i,
  input  logic [1:0]             cfg_addr_i,
  input  logic [31:0]            cfg_wdata_i,
  output logic [31:0]            cfg_rdata_o,
  input  logic                   access_i,    // one lookup result
  input  logic                   hit_i,
  output logic                   tr_en_o,
  output logic                   ldst_en_o,
  output logic [STLB_ASID_W-1:0] asid_o,
  output logic                   flush_o
);

  logic [1:0]             ctrl_q;
  logic [STLB_ASID_W-1:0] asid_q;
  logic [15:0]            lookup_cnt_q;
  logic [15:0]            hit_cnt_q;

  //////////////////////////////////////////////////////////////
  // writable registers
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q <= '0;
      asid_q <= '0;
    end else if (cfg_we_i) begin
      if (cfg_addr_i == CFG_CTRL) ctrl_q <= cfg_wdata_i[1:0];
      if (cfg_addr_i == CFG_ASID) asid_q <= cfg_wdata_i[STLB_ASID_W-1:0];
    end
  end

  // valid bits drop at the edge that takes the write
  assign flush_o = cfg_we_i & (cfg_addr_i == CFG_FLUSH) & cfg_wdata_i[0];

  // wrapping statistics
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lookup_cnt_q <= '0;
      hit_cnt_q    <= '0;
    end else begin
      if (access_i) lookup_cnt_q <= lookup_cnt_q + 16'd1;
      if (hit_i)    hit_cnt_q    <= hit_cnt_q + 16'd1;
    end
  end

  always_comb begin : read_mux
    case (cfg_addr_i)
      CFG_CTRL: cfg_rdata_o = {30'd0, ctrl_q};
      CFG_ASID: cfg_rdata_o = {{(32-STLB_ASID_W){1'b0}}, asid_q};
      CFG_STAT: cfg_rdata_o = {lookup_cnt_q, hit_cnt_q};
      default:  cfg_rdata_o = '0;  // flush reads as zero
    endcase
  end

  assign tr_en_o   = ctrl_q[0];
  assign ldst_en_o = ctrl_q[1];
  assign asid_o    = asid_q;

endmodule

// ==== logic/stlb_fill.sv ====
// shared TLB fill path
// picks the victim way and drives the write strobes from the walker
`timescale 1ns/1ps

module stlb_fill
  import stlb_pkg::*, sv32_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   fill_valid_i,
  input  logic [19:0]            fill_vpn_i,
  input  logic [STLB_ASID_W-1:0] fill_asid_i,
  input  logic                   fill_is_4m_i,
  input  sv32_pte_t              fill_pte_i,
  stlb_ram_if.fill               ram
);

  logic [7:0]            lfsr_q;
  logic                  lfsr_fb;
  logic                  all_valid;
  logic [STLB_WAY_W-1:0] inv_way;
  logic [STLB_WAY_W-1:0] repl_way;

  // lowest numbered free way
  always_comb begin : first_invalid
    inv_way   = '0;
    all_valid = 1'b1;
    for (int w = STLB_WAYS-1; w >= 0; w--) begin
      if (!ram.set_valid[w]) begin
        inv_way   = STLB_WAY_W'(w);
        all_valid = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // random victim, x^8 + x^6 + x^5 + x^4 + 1
  //////////////////////////////////////////////////////////////

  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= 8'h01;
    end else if (fill_valid_i && all_valid) begin  // only on evictions
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

  assign repl_way = all_valid ? lfsr_q[STLB_WAY_W-1:0] : inv_way;

  // write side
  assign ram.wr_way_oh = fill_valid_i ? (STLB_WAYS'(1) << repl_way) : '0;
  assign ram.wr_idx    = fill_vpn_i[STLB_IDX_W-1:0];
  assign ram.wr_tag    = '{asid:  fill_asid_i,
                           vpn1:  fill_vpn_i[19:10],
                           vpn0:  fill_vpn_i[9:0],
                           is_4m: fill_is_4m_i};
  assign ram.wr_pte    = fill_pte_i;

endmodule

// ==== logic/stlb_lookup.sv ====
// shared TLB lookup
// arbitrates first-level misses, reads one set and builds the refill record
`timescale 1ns/1ps

module stlb_lookup
  import stlb_pkg::*, sv32_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   tr_en_i,
  input  logic                   ldst_en_i,
  input  logic [STLB_ASID_W-1:0] asid_i,
  input  logic                   itlb_access_i,
  input  logic                   itlb_hit_i,
  input  logic [31:0]            itlb_vaddr_i,
  input  logic                   dtlb_access_i,
  input  logic                   dtlb_hit_i,
  input  logic [31:0]            dtlb_vaddr_i,
  stlb_ram_if.lookup             ram,
  output logic                   itlb_upd_valid_o,
  output logic [19:0]            itlb_upd_vpn_o,
  output logic [STLB_ASID_W-1:0] itlb_upd_asid_o,
  output logic                   itlb_upd_is_4m_o,
  output sv32_pte_t              itlb_upd_pte_o,
  output logic                   dtlb_upd_valid_o,
  output logic [19:0]            dtlb_upd_vpn_o,
  output logic [STLB_ASID_W-1:0] dtlb_upd_asid_o,
  output logic                   dtlb_upd_is_4m_o,
  output sv32_pte_t              dtlb_upd_pte_o,
  output logic                   itlb_miss_o,
  output logic                   dtlb_miss_o,
  output logic                   access_o,
  output logic                   hit_o,
  output logic [31:0]            vaddr_o,
  output logic                   itlb_req_o
);

  sv32_vaddr_u            req_va;
  sv32_vaddr_u            vaddr_q;
  logic                   access_q;
  logic                   itlb_req_q;
  logic [STLB_ASID_W-1:0] asid_q;
  logic [STLB_WAYS-1:0]   way_hit;
  logic                   hit;
  stlb_tag_t              hit_tag;
  sv32_pte_t              hit_pte;

  //////////////////////////////////////////////////////////////
  // miss arbitration, data side first
  //////////////////////////////////////////////////////////////

  assign itlb_miss_o = tr_en_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;
  assign dtlb_miss_o = ldst_en_i & dtlb_access_i & ~dtlb_hit_i;

  assign req_va     = itlb_miss_o ? itlb_vaddr_i : dtlb_vaddr_i;
  assign ram.rd_en  = itlb_miss_o | dtlb_miss_o;
  assign ram.rd_idx = req_va.set.idx;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      access_q   <= 1'b0;
      itlb_req_q <= 1'b0;
      vaddr_q    <= '0;
      asid_q     <= '0;
    end else begin
      access_q   <= ram.rd_en;
      itlb_req_q <= itlb_miss_o;
      if (ram.rd_en) begin
        vaddr_q <= req_va;
        asid_q  <= asid_i;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // tag compare on the RAM outputs
  //////////////////////////////////////////////////////////////

  always_comb begin : tag_compare
    way_hit = '0;
    for (int w = 0; w < STLB_WAYS; w++) begin
      way_hit[w] = ram.rd_valid[w]
                 & (ram.rd_tag[w].vpn1 == vaddr_q.page.vpn1)
                 & ((ram.rd_tag[w].asid == asid_q) | ram.rd_pte[w].g)
                 & (ram.rd_tag[w].is_4m | (ram.rd_tag[w].vpn0 == vaddr_q.page.vpn0));
    end
  end

  // displaced reads report a miss
  assign hit = access_q & ram.rd_ok & (|way_hit);

  always_comb begin : way_select
    hit_tag = ram.rd_tag[0];
    hit_pte = ram.rd_pte[0];
    for (int w = STLB_WAYS-1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_tag = ram.rd_tag[w];
        hit_pte = ram.rd_pte[w];
      end
    end
  end

  // refill records, idle fields held at zero
  assign itlb_upd_valid_o = hit & itlb_req_q;
  assign itlb_upd_vpn_o   = itlb_upd_valid_o ? {vaddr_q.page.vpn1, vaddr_q.page.vpn0} : '0;
  assign itlb_upd_asid_o  = itlb_upd_valid_o ? asid_q : '0;
  assign itlb_upd_is_4m_o = itlb_upd_valid_o & hit_tag.is_4m;
  assign itlb_upd_pte_o   = itlb_upd_valid_o ? hit_pte : '0;

  assign dtlb_upd_valid_o = hit & ~itlb_req_q;
  assign dtlb_upd_vpn_o   = dtlb_upd_valid_o ? {vaddr_q.page.vpn1, vaddr_q.page.vpn0} : '0;
  assign dtlb_upd_asid_o  = dtlb_upd_valid_o ? asid_q : '0;
  assign dtlb_upd_is_4m_o = dtlb_upd_valid_o & hit_tag.is_4m;
  assign dtlb_upd_pte_o   = dtlb_upd_valid_o ? hit_pte : '0;

  assign access_o   = access_q;
  assign hit_o      = hit;
  assign vaddr_o    = vaddr_q;
  assign itlb_req_o = itlb_req_q;

endmodule

// ==== logic/stlb_pkg.sv ====
// shared TLB geometry, tag record and configuration map

package stlb_pkg;

  // fixed geometry
  localparam int STLB_SETS   = 64;
  localparam int STLB_WAYS   = 2;
  localparam int STLB_IDX_W  = 6;                  // log2 of the set count
  localparam int STLB_WAY_W  = $clog2(STLB_WAYS);
  localparam int STLB_ASID_W = 9;

  // one tag entry per way and set
  typedef struct packed {
    logic [STLB_ASID_W-1:0] asid;
    logic [9:0]             vpn1;
    logic [9:0]             vpn0;
    logic                   is_4m;  // superpage, vpn0 not compared
  } stlb_tag_t;

  //////////////////////////////////////////////////////////////
  // configuration register map
  //////////////////////////////////////////////////////////////

  // bit 0 instr translation, bit 1 load/store translation
  localparam logic [1:0] CFG_CTRL  = 2'd0;
  // asid in bits 8:0
  localparam logic [1:0] CFG_ASID  = 2'd1;
  // write 1 to bit 0 to drop every entry
  localparam logic [1:0] CFG_FLUSH = 2'd2;
  // lookups in 31:16, hits in 15:0
  localparam logic [1:0] CFG_STAT  = 2'd3;

endpackage

// ==== logic/stlb_ram_if.sv ====
// storage port bundle shared by lookup, fill and the tag/PTE store
// read side is owned by lookup, write side by fill
`timescale 1ns/1ps

interface stlb_ram_if
  import stlb_pkg::*, sv32_pkg::*;
();

  // read port
  logic                                rd_en;
  logic [STLB_IDX_W-1:0]               rd_idx;
  stlb_tag_t [STLB_WAYS-1:0]           rd_tag;
  sv32_pte_t [STLB_WAYS-1:0]           rd_pte;
  logic [STLB_WAYS-1:0]                rd_valid;
  logic                                rd_ok;    // read really happened last cycle

  // write port
  logic [STLB_WAYS-1:0]                wr_way_oh;
  logic [STLB_IDX_W-1:0]               wr_idx;
  stlb_tag_t                           wr_tag;
  sv32_pte_t                           wr_pte;
  logic [STLB_WAYS-1:0]                set_valid;  // valid bits at wr_idx, comb

  modport lookup (
    output rd_en, rd_idx,
    input  rd_tag, rd_pte, rd_valid, rd_ok
  );

  modport fill (
    output wr_way_oh, wr_idx, wr_tag, wr_pte,
    input  set_valid
  );

  modport store (
    input  rd_en, rd_idx, wr_way_oh, wr_idx, wr_tag, wr_pte,
    output rd_tag, rd_pte, rd_valid, rd_ok, set_valid
  );

endinterface

// ==== logic/stlb_store.sv ====
// shared TLB storage
// per-way tag and PTE arrays with registered read, plus the valid flops
`timescale 1ns/1ps

module stlb_store
  import stlb_pkg::*, sv32_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           flush_i,
  stlb_ram_if.store      ram
);

  stlb_tag_t tag_mem [STLB_WAYS][STLB_SETS];
  sv32_pte_t pte_mem [STLB_WAYS][STLB_SETS];

  logic [STLB_SETS-1:0][STLB_WAYS-1:0] valid_q;
  logic                                wr_any;
  logic                                rd_go;

  // single index port per way, a write displaces the read
  assign wr_any = |ram.wr_way_oh;
  assign rd_go  = ram.rd_en & ~wr_any;

  //////////////////////////////////////////////////////////////
  // tag and PTE arrays
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : ram_access
    for (int w = 0; w < STLB_WAYS; w++) begin
      if (ram.wr_way_oh[w]) begin
        tag_mem[w][ram.wr_idx] <= ram.wr_tag;
        pte_mem[w][ram.wr_idx] <= ram.wr_pte;
      end
      if (rd_go) begin
        ram.rd_tag[w] <= tag_mem[w][ram.rd_idx];
        ram.rd_pte[w] <= pte_mem[w][ram.rd_idx];
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // valid bits
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;                   // flush wins over a fill
    end else if (wr_any) begin
      valid_q[ram.wr_idx] <= valid_q[ram.wr_idx] | ram.wr_way_oh;
    end
  end

  // valid bits of the read set travel with the RAM data
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ram.rd_valid <= '0;
      ram.rd_ok    <= 1'b0;
    end else begin
      ram.rd_ok <= rd_go;
      if (rd_go) begin
        ram.rd_valid <= flush_i ? '0 : valid_q[ram.rd_idx];
      end
    end
  end

  // replacement needs the fill set right away
  assign ram.set_valid = valid_q[ram.wr_idx];

endmodule

// ==== logic/stlb_top.sv ====
// shared second-level TLB for sv32, two ways by 64 sets
// serves ITLB and DTLB misses, filled by an external page-table walker
`timescale 1ns/1ps

module stlb_top
  import stlb_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // configuration
  input  logic                   cfg_we_i,
  input  logic [1:0]             cfg_addr_i,
  input  logic [31:0]            cfg_wdata_i,
  output logic [31:0]            cfg_rdata_o,
  // first-level TLBs
  input  logic                   itlb_access_i,
  input  logic                   itlb_hit_i,
  input  logic [31:0]            itlb_vaddr_i,
  input  logic                   dtlb_access_i,
  input  logic                   dtlb_hit_i,
  input  logic [31:0]            dtlb_vaddr_i,
  // walker fill
  input  logic                   fill_valid_i,
  input  logic [19:0]            fill_vpn_i,
  input  logic [STLB_ASID_W-1:0] fill_asid_i,
  input  logic                   fill_is_4m_i,
  input  logic [31:0]            fill_pte_i,
  // refill records
  output logic                   itlb_upd_valid_o,
  output logic [19:0]            itlb_upd_vpn_o,
  output logic [STLB_ASID_W-1:0] itlb_upd_asid_o,
  output logic                   itlb_upd_is_4m_o,
  output logic [31:0]            itlb_upd_pte_o,
  output logic                   dtlb_upd_valid_o,
  output logic [19:0]            dtlb_upd_vpn_o,
  output logic [STLB_ASID_W-1:0] dtlb_upd_asid_o,
  output logic                   dtlb_upd_is_4m_o,
  output logic [31:0]            dtlb_upd_pte_o,
  // status
  output logic                   itlb_miss_o,
  output logic                   dtlb_miss_o,
  output logic                   stlb_access_o,
  output logic                   stlb_hit_o,
  output logic [31:0]            stlb_vaddr_o,
  output logic                   itlb_req_o
);

  logic                   tr_en;
  logic                   ldst_en;
  logic [STLB_ASID_W-1:0] asid;
  logic                   flush;

  stlb_ram_if ram_if ();

  //////////////////////////////////////////////////////////////
  // configuration and statistics
  //////////////////////////////////////////////////////////////

  stlb_cfg_regs u_cfg (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .access_i    (stlb_access_o),
    .hit_i       (stlb_hit_o),
    .tr_en_o     (tr_en),
    .ldst_en_o   (ldst_en),
    .asid_o      (asid),
    .flush_o     (flush)
  );

  //////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////

  stlb_store u_store (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush),
    .ram      (ram_if)
  );

  stlb_fill u_fill (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .fill_valid_i (fill_valid_i),
    .fill_vpn_i   (fill_vpn_i),
    .fill_asid_i  (fill_asid_i),
    .fill_is_4m_i (fill_is_4m_i),
    .fill_pte_i   (fill_pte_i),
    .ram          (ram_if)
  );

  stlb_lookup u_lookup (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .tr_en_i          (tr_en),
    .ldst_en_i        (ldst_en),
    .asid_i           (asid),
    .itlb_access_i    (itlb_access_i),
    .itlb_hit_i       (itlb_hit_i),
    .itlb_vaddr_i     (itlb_vaddr_i),
    .dtlb_access_i    (dtlb_access_i),
    .dtlb_hit_i       (dtlb_hit_i),
    .dtlb_vaddr_i     (dtlb_vaddr_i),
    .ram              (ram_if),
    .itlb_upd_valid_o (itlb_upd_valid_o),
    .itlb_upd_vpn_o   (itlb_upd_vpn_o),
    .itlb_upd_asid_o  (itlb_upd_asid_o),
    .itlb_upd_is_4m_o (itlb_upd_is_4m_o),
    .itlb_upd_pte_o   (itlb_upd_pte_o),
    .dtlb_upd_valid_o (dtlb_upd_valid_o),
    .dtlb_upd_vpn_o   (dtlb_upd_vpn_o),
    .dtlb_upd_asid_o  (dtlb_upd_asid_o),
    .dtlb_upd_is_4m_o (dtlb_upd_is_4m_o),
    .dtlb_upd_pte_o   (dtlb_upd_pte_o),
    .itlb_miss_o      (itlb_miss_o),
    .dtlb_miss_o      (dtlb_miss_o),
    .access_o         (stlb_access_o),
    .hit_o            (stlb_hit_o),
    .vaddr_o          (stlb_vaddr_o),
    .itlb_req_o       (itlb_req_o)
  );

endmodule

// ==== logic/sv32_pkg.sv ====
// sv32 architectural types
// virtual address with page and set decodes, and the leaf PTE layout

package sv32_pkg;

  //////////////////////////////////////////////////////////////
  // virtual address
  //////////////////////////////////////////////////////////////

  // page-table view of the address
  typedef struct packed {
    logic [9:0]  vpn1;
    logic [9:0]  vpn0;
    logic [11:0] offset;
  } sv32_page_t;

  // shared TLB view, set index is the low six vpn bits
  typedef struct packed {
    logic [13:0] tag;
    logic [5:0]  idx;     // vaddr[17:12]
    logic [11:0] offset;
  } sv32_set_t;

  typedef union packed {
    sv32_page_t page;
    sv32_set_t  set;
  } sv32_vaddr_u;

  //////////////////////////////////////////////////////////////
  // page table entry
  //////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [21:0] ppn;
    logic [1:0]  rsw;   // reserved for software
    logic        d;
    logic        a;
    logic        g;     // global mapping, matches any asid
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } sv32_pte_t;

endpackage

// ==== src.f ====
logic/sv32_pkg.sv
logic/stlb_pkg.sv
logic/stlb_ram_if.sv
logic/stlb_cfg_regs.sv
logic/stlb_store.sv
logic/stlb_fill.sv
logic/stlb_lookup.sv
logic/stlb_top.sv
testbench/tb_clkgen.sv
testbench/stlb_sva.sv
testbench/stlb_tb.sv

// ==== testbench/stlb_sva.sv ====
// shared TLB output rules
// bound to the top level, checks refill and hit consistency
`timescale 1ns/1ps

module stlb_sva (
  input logic clk_i,
  input logic arst_n_i,
  input logic itlb_upd_valid_o,
  input logic dtlb_upd_valid_o,
  input logic stlb_hit_o,
  input logic stlb_access_o
);

  int fail_cnt = 0;  // failed rules so far

  // one requester per result
  one_refill : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(itlb_upd_valid_o && dtlb_upd_valid_o))
    else begin
      $error("both refill records valid in one cycle");
      fail_cnt++;
    end

  hit_needs_access : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stlb_hit_o |-> stlb_access_o)
    else begin
      $error("hit reported without a lookup");
      fail_cnt++;
    end

  refill_needs_hit : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (itlb_upd_valid_o || dtlb_upd_valid_o) |-> stlb_hit_o)
    else begin
      $error("refill record sent without a hit");
      fail_cnt++;
    end

endmodule

bind stlb_top stlb_sva u_sva (.*);

// ==== testbench/stlb_tb.sv ====
// shared TLB testbench
// walker and first-level TLB stimulus, reference model of the entries, checker
`timescale 1ns/1ps

module stlb_tb
  import sv32_pkg::*, stlb_pkg::*;
();

  logic        clk;
  logic        arst_n_i;
  logic        cfg_we_i;
  logic [1:0]  cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic [31:0] cfg_rdata_o;
  logic        itlb_access_i, itlb_hit_i, dtlb_access_i, dtlb_hit_i;
  logic [31:0] itlb_vaddr_i, dtlb_vaddr_i;
  logic        fill_valid_i, fill_is_4m_i;
  logic [19:0] fill_vpn_i;
  logic [8:0]  fill_asid_i;
  logic [31:0] fill_pte_i;
  logic        itlb_upd_valid_o, itlb_upd_is_4m_o, dtlb_upd_valid_o, dtlb_upd_is_4m_o;
  logic [19:0] itlb_upd_vpn_o, dtlb_upd_vpn_o;
  logic [8:0]  itlb_upd_asid_o, dtlb_upd_asid_o;
  logic [31:0] itlb_upd_pte_o, dtlb_upd_pte_o;
  logic        itlb_miss_o, dtlb_miss_o, stlb_access_o, stlb_hit_o, itlb_req_o;
  logic [31:0] stlb_vaddr_o;

  // reference model, three slots per set so an eviction can be tracked
  logic        m_val    [STLB_SETS][3];
  logic        m_unsure [STLB_SETS][3];   // may have been evicted
  logic [19:0] m_vpn    [STLB_SETS][3];
  logic [8:0]  m_tasid  [STLB_SETS][3];
  logic        m_4m     [STLB_SETS][3];
  logic [31:0] m_pte    [STLB_SETS][3];
  logic [1:0]  cur_ctrl;
  logic [8:0]  cur_asid;
  int          m_lookups, m_hits, maybe_hits;
  int          errors, checks, tests, test_err0;

  // expectation handed from the driver to the checker
  logic        issue_flag;
  logic        p_access, p_itlb, p_4m, c_access, c_itlb, c_4m;
  logic [31:0] p_va, p_pte, c_va, c_pte;
  logic [8:0]  p_asid, c_asid;
  int          p_exp, c_exp;
  logic [19:0] filled [$];

  tb_clkgen u_clk (.clk_o(clk));

  stlb_top dut (.clk_i(clk), .*);

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_timeout(input string what);
    $display("timeout: %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s (%0d errors)", tests, name,
             (errors == test_err0) ? "ok" : "BAD", errors - test_err0);
    test_err0 = errors;
  endtask

  //////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////

  // 0 miss, 1 hit, 2 entry may be gone
  function automatic int predict(input logic [31:0] va_raw, input logic [8:0] asid,
                                 output logic [31:0] pte, output logic is4m);
    sv32_vaddr_u va;
    int          res;
    int          idx;
    va   = va_raw;
    res  = 0;
    pte  = '0;
    is4m = 1'b0;
    idx  = va.set.idx;
    for (int s = 0; s < 3; s++) begin
      if (m_val[idx][s] && m_vpn[idx][s][19:10] == va.page.vpn1 &&
          (m_tasid[idx][s] == asid || m_pte[idx][s][5]) &&
          (m_4m[idx][s] || m_vpn[idx][s][9:0] == va.page.vpn0)) begin
        if (m_unsure[idx][s]) begin
          if (res == 0) res = 2;
        end else begin
          res  = 1;
          pte  = m_pte[idx][s];
          is4m = m_4m[idx][s];
        end
      end
    end
    return res;
  endfunction

  task automatic model_fill(input logic [19:0] vpn, input logic [8:0] asid,
                            input logic is4m, input logic [31:0] pte);
    int idx;
    int s;
    idx = vpn[5:0];
    if (!m_val[idx][0]) s = 0;
    else if (!m_val[idx][1]) s = 1;
    else begin
      s = 2;                              // replaces one of the first two
      m_unsure[idx][0] = 1'b1;
      m_unsure[idx][1] = 1'b1;
    end
    m_val[idx][s]    = 1'b1;
    m_unsure[idx][s] = 1'b0;
    m_vpn[idx][s]    = vpn;
    m_tasid[idx][s]  = asid;
    m_4m[idx][s]     = is4m;
    m_pte[idx][s]    = pte;
  endtask

  task automatic model_clear();
    for (int i = 0; i < STLB_SETS; i++) begin
      for (int s = 0; s < 3; s++) begin
        m_val[i][s]    = 1'b0;
        m_unsure[i][s] = 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////
  // bus tasks
  //////////////////////////////////////////////////////////////

  task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
    @(negedge clk);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(negedge clk);
    cfg_we_i = 1'b0;
    if (addr == CFG_CTRL) cur_ctrl = data[1:0];
    if (addr == CFG_ASID) cur_asid = data[8:0];
    if (addr == CFG_FLUSH && data[0]) model_clear();
  endtask

  task automatic cfg_read(input logic [1:0] addr, output logic [31:0] data);
    @(negedge clk);
    cfg_addr_i = addr;
    #1 data = cfg_rdata_o;
  endtask

  task automatic fill(input logic [19:0] vpn, input logic [8:0] asid,
                      input logic is4m, input logic [31:0] pte);
    @(negedge clk);
    fill_valid_i = 1'b1;
    fill_vpn_i   = vpn;
    fill_asid_i  = asid;
    fill_is_4m_i = is4m;
    fill_pte_i   = pte;
    @(negedge clk);
    fill_valid_i = 1'b0;
    model_fill(vpn, asid, is4m, pte);
  endtask

  task automatic request(input logic i_acc, input logic d_acc,
                         input logic [31:0] i_va, input logic [31:0] d_va);
    logic imiss;
    logic dmiss;
    int   cnt;
    imiss    = cur_ctrl[0] & i_acc & ~d_acc;
    dmiss    = cur_ctrl[1] & d_acc;
    p_access = imiss | dmiss;
    p_itlb   = imiss;
    p_va     = imiss ? i_va : d_va;
    p_asid   = cur_asid;
    p_exp    = p_access ? predict(p_va, cur_asid, p_pte, p_4m) : 0;
    @(negedge clk);
    itlb_access_i = i_acc;
    itlb_vaddr_i  = i_va;
    dtlb_access_i = d_acc;
    dtlb_vaddr_i  = d_va;
    #1;
    check("itlb_miss_o", itlb_miss_o, imiss);
    check("dtlb_miss_o", dtlb_miss_o, dmiss);
    issue_flag = 1'b1;
    @(negedge clk);
    itlb_access_i = 1'b0;
    dtlb_access_i = 1'b0;
    cnt = 0;
    while (issue_flag) begin
      @(negedge clk);
      cnt++;
      if (cnt > 20) abort_timeout("lookup result was never checked");
    end
  endtask

  //////////////////////////////////////////////////////////////
  // result checker, one cycle after the request edge
  //////////////////////////////////////////////////////////////

  task automatic check_result();
    check("stlb_access_o", stlb_access_o, c_access);
    if (c_access) begin
      m_lookups++;
      check("itlb_req_o", itlb_req_o, c_itlb);
      check("stlb_vaddr_o", stlb_vaddr_o, c_va);
    end
    if (c_exp == 2) begin
      if (stlb_hit_o) maybe_hits++;
    end else if (c_exp == 1) begin
      m_hits++;
      check("stlb_hit_o", stlb_hit_o, 1'b1);
      check("itlb_upd_valid_o", itlb_upd_valid_o, c_itlb);
      check("dtlb_upd_valid_o", dtlb_upd_valid_o, !c_itlb);
      check("upd_vpn", c_itlb ? itlb_upd_vpn_o : dtlb_upd_vpn_o, c_va[31:12]);
      check("upd_asid", c_itlb ? itlb_upd_asid_o : dtlb_upd_asid_o, c_asid);
      check("upd_is_4m", c_itlb ? itlb_upd_is_4m_o : dtlb_upd_is_4m_o, c_4m);
      check("upd_pte", c_itlb ? itlb_upd_pte_o : dtlb_upd_pte_o, c_pte);
    end else begin
      check("stlb_hit_o", stlb_hit_o, 1'b0);
      check("itlb_upd_valid_o", itlb_upd_valid_o, 1'b0);
      check("dtlb_upd_valid_o", dtlb_upd_valid_o, 1'b0);
    end
  endtask

  // request edge just passed, the result is on the outputs now
  always @(posedge clk) begin
    #10;
    if (issue_flag) begin
      c_access   = p_access;
      c_itlb     = p_itlb;
      c_va       = p_va;
      c_asid     = p_asid;
      c_exp      = p_exp;
      c_pte      = p_pte;
      c_4m       = p_4m;
      issue_flag = 1'b0;
      check_result();
    end
  end

  //////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [19:0] vpn;
    logic [31:0] va;
    logic [31:0] pte;
    logic        is4m;
    logic        sel;
    void'($urandom(85));
    arst_n_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    itlb_access_i = 1'b0;
    itlb_hit_i = 1'b0;
    itlb_vaddr_i = '0;
    dtlb_access_i = 1'b0;
    dtlb_hit_i = 1'b0;
    dtlb_vaddr_i = '0;
    fill_valid_i = 1'b0;
    fill_vpn_i = '0;
    fill_asid_i = '0;
    fill_is_4m_i = 1'b0;
    fill_pte_i = '0;
    issue_flag = 1'b0;
    cur_ctrl = '0;
    cur_asid = '0;
    {m_lookups, m_hits, maybe_hits, errors, checks, tests, test_err0} = '0;
    model_clear();
    repeat (16) @(negedge clk);
    arst_n_i = 1'b1;

    // reset state and register access
    cfg_read(CFG_STAT, rd);
    check("cfg_rdata_o", rd, 32'h0);
    request(1'b1, 1'b0, 32'h1234_5678, 32'h0);
    request(1'b0, 1'b1, 32'h0, 32'h1234_5678);
    cfg_write(CFG_CTRL, 32'h3);
    cfg_read(CFG_CTRL, rd);
    check("cfg_rdata_o", rd, 32'h3);
    cfg_write(CFG_ASID, 32'h15A);
    cfg_read(CFG_ASID, rd);
    check("cfg_rdata_o", rd, 32'h15A);
    end_test("reset state");

    // fill then ITLB lookup
    fill(20'h12345, 9'h15A, 1'b0, 32'hABCD_E0CF);
    request(1'b1, 1'b0, 32'h1234_5ABC, 32'h0);
    end_test("fill then itlb lookup");

    // asid, global, superpage and vpn1 rules
    cfg_write(CFG_ASID, 32'h0A3);
    request(1'b1, 1'b0, 32'h1234_5ABC, 32'h0);
    fill(20'h2A0C1, 9'h111, 1'b0, 32'h0055_10E1);
    request(0, 1, 32'h0, 32'h2A0C_1000);
    fill({10'h155, 10'h007}, 9'h0A3, 1'b1, 32'h0F00_00C7);
    request(0, 1, 32'h0, {10'h155, 10'h3C7, 12'h010});
    request(1, 0, {10'h156, 10'h007, 12'h0}, 32'h0);
    end_test("matching rules");

    // data side wins, enables gate each side
    request(1, 1, {10'h155, 10'h047, 12'h0}, 32'h2A0C_1444);
    cfg_write(CFG_CTRL, 32'h1);
    request(0, 1, 32'h0, 32'h2A0C_1000);
    request(1, 0, 32'h2A0C_1000, 32'h0);
    cfg_write(CFG_CTRL, 32'h2);
    request(1, 0, 32'h2A0C_1000, 32'h0);
    cfg_write(CFG_CTRL, 32'h3);
    end_test("arbitration");

    // three fills to set 0x21
    fill(20'h10021, 9'h0A3, 1'b0, 32'h0001_00CF);
    fill(20'h20021, 9'h0A3, 1'b0, 32'h0002_00CF);
    fill(20'h30021, 9'h0A3, 1'b0, 32'h0003_00CF);
    request(1, 0, 32'h3002_1000, 32'h0);
    maybe_hits = 0;
    request(1, 0, 32'h1002_1000, 32'h0);
    request(0, 1, 32'h0, 32'h2002_1000);
    checks++;
    assert (maybe_hits == 1) else begin
      $display("replacement left %0d of the two older entries, one expected", maybe_hits);
      errors++;
    end
    m_hits += maybe_hits;
    end_test("replacement");

    // flush, then a random run and the counters
    cfg_write(CFG_FLUSH, 32'h1);
    request(1, 0, 32'h1234_5ABC, 32'h0);
    request(0, 1, 32'h0, 32'h3002_1000);
    request(0, 1, 32'h0, 32'h2A0C_1000);
    for (int i = 0; i < 60; i++) begin
      if ($urandom % 2) begin
        vpn = $urandom;
        if (!(m_val[vpn[5:0]][0] && m_val[vpn[5:0]][1]) &&
            predict({vpn, 12'h0}, cur_asid, pte, is4m) == 0) begin
          fill(vpn, cur_asid, 1'b0, ($urandom & ~32'h20) | 32'h1);
          filled.push_back(vpn);
        end
      end else begin
        if (filled.size() > 0 && ($urandom % 4) != 0) vpn = filled[$urandom % filled.size()];
        else vpn = $urandom;
        va  = {vpn, 12'($urandom)};
        sel = $urandom % 2;
        request(sel, !sel, va, va);
      end
    end
    cfg_read(CFG_STAT, rd);
    check("cfg_rdata_o", rd, {m_lookups[15:0], m_hits[15:0]});
    end_test("flush and counters");

    errors += dut.u_sva.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_clkgen.sv ====
// testbench clock source, 40 ns period
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o
);

  localparam time HALF_PERIOD = 20ns;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

endmodule
